// File: verilog/ex_consts.svh
/*
  Widths and iteration count for the integer execute stage.
  EX_MD_STEPS must equal EX_XLEN, because the multiplier and divider
  retire exactly one operand bit per step.
*/

`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Data path width in bits
`define EX_XLEN 32

// Destination register address width
`define EX_REG_AW 5

// Opcode field width, enough for the 20 operations
`define EX_OP_W 5

// Multiply/divide iterations, one bit per step
`define EX_MD_STEPS `EX_XLEN

`endif

// File: verilog/ex_op_pkg.sv
/*
  Operation opcodes seen on the issue port of the execute stage.
  Encodings 20 and up are unused and are ignored by both units.
*/

`include "ex_consts.svh"

package ex_op_pkg;

  typedef enum logic [`EX_OP_W-1:0] {
    // Arithmetic and logic
    ADD, SUB, AND, OR, XOR,
    // Shifts, amount from low 5 bits of op_b
    SLL, SRL, SRA,
    // Set-less-than
    SLT, SLTU,
    // Branch compares, no register result
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    // Iterative unit, unsigned only
    MUL, MULHU, DIVU, REMU
  } ex_op_e;

endpackage

// File: verilog/ex_ctrl_pkg.sv
/*
  Control types shared by the execute stage units.
  ex_wb_t is 37 bits: result word in the upper bits, rd in the lower bits.
*/

`include "ex_consts.svh"

package ex_ctrl_pkg;

  // Multiply/divide sequencer states
  typedef enum logic [1:0] {IDLE, MULT, DIV, DONE} md_state_e;

  // One finished result on its way to the EX/WB register
  typedef struct packed {
    logic [`EX_XLEN-1:0]   result;
    logic [`EX_REG_AW-1:0] rd;
  } ex_wb_t;

endpackage

// File: verilog/ex_result_if.sv
/*
  Result handshake from one execute unit to the writeback register.
  A result moves on a clock edge with valid and ready both high.
  The unit keeps payload stable while valid is high and ready is low.
*/

`timescale 1ns/100ps

interface ex_result_if;
  import ex_ctrl_pkg::*;

  // Unit has a finished result
  logic   valid;
  // Writeback register can take it
  logic   ready;
  // Result word and destination register
  ex_wb_t payload;

  // Producer side, one per unit
  modport unit (
    output valid,
    output payload,
    input  ready
  );

  // Consumer side, the EX/WB register
  modport wb (
    input  valid,
    input  payload,
    output ready
  );

endinterface

// File: verilog/ex_alu.sv
/*
  Single-cycle ALU and branch compare, purely combinational.
  Result valid is only raised for the cycle the issue is accepted.
  Branches return zero and are meant to be issued with rd 0.
*/

`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_alu (
  input  logic                  issue_valid_i,
  input  logic                  issue_ready_i,
  input  ex_op_pkg::ex_op_e     issue_op_i,
  input  logic [`EX_XLEN-1:0]   op_a_i,
  input  logic [`EX_XLEN-1:0]   op_b_i,
  input  logic [`EX_REG_AW-1:0] rd_i,
  output logic                  branch_taken_o,
  ex_result_if.unit             res
);
  import ex_op_pkg::*;

  logic                alu_op;
  logic                branch_op;
  logic                cmp_true;
  logic                eq;
  logic                lt_signed;
  logic                lt_unsigned;
  logic [4:0]          shamt;
  logic [`EX_XLEN-1:0] alu_result;

  ////////////////////////////////////////////////////////////////////////////
  // Compare and shift helpers
  ////////////////////////////////////////////////////////////////////////////

  assign eq          = (op_a_i == op_b_i);
  assign lt_signed   = ($signed(op_a_i) < $signed(op_b_i));
  assign lt_unsigned = (op_a_i < op_b_i);
  // RV32 shifts only look at the low 5 bits
  assign shamt       = op_b_i[4:0];

  ////////////////////////////////////////////////////////////////////////////
  // Operation decode and result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_result = '0;
    alu_op     = 1'b1;
    branch_op  = 1'b0;
    cmp_true   = 1'b0;
    case (issue_op_i)
      ADD:  alu_result = op_a_i + op_b_i;
      SUB:  alu_result = op_a_i - op_b_i;
      AND:  alu_result = op_a_i & op_b_i;
      OR:   alu_result = op_a_i | op_b_i;
      XOR:  alu_result = op_a_i ^ op_b_i;
      SLL:  alu_result = op_a_i << shamt;
      SRL:  alu_result = op_a_i >> shamt;
      // Arithmetic shift keeps the sign of op_a
      SRA:  alu_result = $signed(op_a_i) >>> shamt;
      SLT:  alu_result = {{(`EX_XLEN-1){1'b0}}, lt_signed};
      SLTU: alu_result = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
      // Branches leave the result at zero
      BEQ: begin
        branch_op = 1'b1;
        cmp_true  = eq;
      end
      BNE: begin
        branch_op = 1'b1;
        cmp_true  = !eq;
      end
      BLT: begin
        branch_op = 1'b1;
        cmp_true  = lt_signed;
      end
      BGE: begin
        branch_op = 1'b1;
        cmp_true  = !lt_signed;
      end
      BLTU: begin
        branch_op = 1'b1;
        cmp_true  = lt_unsigned;
      end
      BGEU: begin
        branch_op = 1'b1;
        cmp_true  = !lt_unsigned;
      end
      // Multiply/divide and unused encodings belong elsewhere
      default: alu_op = 1'b0;
    endcase
  end

  // Branch decision leaves the stage in the issue cycle
  assign branch_taken_o = issue_valid_i && branch_op && cmp_true;

  // Result valid only when the issue is actually taken
  assign res.valid   = issue_valid_i && issue_ready_i && alu_op;
  assign res.payload = {alu_result, rd_i};

endmodule

// File: verilog/ex_muldiv.sv
/*
  Iterative unsigned multiply (shift-add) and divide (restoring).
  Takes EX_MD_STEPS cycles after accept, then holds its result in DONE
  until the writeback register takes it. Signed variants are not handled.
  Divide by zero gives all ones for DIVU and the dividend for REMU.
*/

`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_muldiv (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue_valid_i,
  input  logic                  issue_ready_i,
  input  ex_op_pkg::ex_op_e     issue_op_i,
  input  logic [`EX_XLEN-1:0]   op_a_i,
  input  logic [`EX_XLEN-1:0]   op_b_i,
  input  logic [`EX_REG_AW-1:0] rd_i,
  output logic                  busy_o,
  ex_result_if.unit             res
);
  import ex_op_pkg::*;
  import ex_ctrl_pkg::*;

  md_state_e                       state_q;
  logic [$clog2(`EX_MD_STEPS)-1:0] step_q;
  logic                            md_op;
  logic                            accept;
  logic                            last_step;
  ex_op_e                          op_q;
  logic [`EX_REG_AW-1:0]           rd_q;
  // hi:lo is the product, or remainder:quotient while dividing
  logic [`EX_XLEN-1:0]             hi_q;
  logic [`EX_XLEN-1:0]             lo_q;
  // Multiplicand or divisor
  logic [`EX_XLEN-1:0]             b_q;
  logic [`EX_XLEN:0]               mul_sum;
  logic [`EX_XLEN:0]               div_shift;
  logic                            div_ge;
  logic [`EX_XLEN:0]               div_rem;
  logic [`EX_XLEN-1:0]             res_word;

  assign md_op     = issue_op_i inside {MUL, MULHU, DIVU, REMU};
  assign accept    = issue_valid_i && issue_ready_i && md_op && (state_q == IDLE);
  assign last_step = (int'(step_q) == `EX_MD_STEPS - 1);

  ////////////////////////////////////////////////////////////////////////////
  // Step datapath
  ////////////////////////////////////////////////////////////////////////////

  // Multiply: add b into the upper half when the low bit is set, carry kept
  assign mul_sum = {1'b0, hi_q} + {1'b0, (lo_q[0] ? b_q : '0)};

  // Divide: bring in the next dividend bit, subtract if it fits
  assign div_shift = {hi_q, lo_q[`EX_XLEN-1]};
  assign div_ge    = (div_shift >= {1'b0, b_q});
  assign div_rem   = div_ge ? (div_shift - {1'b0, b_q}) : div_shift;

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q <= issue_op_i;
      rd_q <= rd_i;
      b_q  <= op_b_i;
      hi_q <= '0;
      lo_q <= op_a_i;
    end else if (state_q == MULT) begin
      // Shift the sum and the consumed multiplier bit right together
      {hi_q, lo_q} <= {mul_sum, lo_q[`EX_XLEN-1:1]};
    end else if (state_q == DIV) begin
      // Remainder fits the word, quotient bit enters from the right
      hi_q <= div_rem[`EX_XLEN-1:0];
      lo_q <= {lo_q[`EX_XLEN-2:0], div_ge};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= (issue_op_i inside {MUL, MULHU}) ? MULT : DIV;
            step_q  <= '0;
          end
        end
        MULT, DIV: begin
          step_q <= step_q + 1'b1;
          if (last_step) begin
            state_q <= DONE;
          end
        end
        // Hold the result until the writeback register takes it
        DONE: begin
          if (res.ready) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Low word for MUL and quotient, high word for MULHU and remainder
  assign res_word = (op_q inside {MUL, DIVU}) ? lo_q : hi_q;

  assign res.valid   = (state_q == DONE);
  assign res.payload = {res_word, rd_q};
  assign busy_o      = (state_q != IDLE);

endmodule

// File: verilog/ex_wb_reg.sv
/*
  EX/WB register fed by the ALU and the multiply/divide unit.
  Only one unit offers a result in any cycle; the ALU wins if both do.
  Issue stalls while the register is full and not draining, or while
  the multiply/divide unit is working.
*/

`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_wb_reg (
  input  logic                  clk,
  input  logic                  rst_n,
  ex_result_if.wb               alu_res,
  ex_result_if.wb               md_res,
  input  logic                  md_busy_i,
  input  logic                  wb_ready_i,
  output logic                  issue_ready_o,
  output logic                  wb_valid_o,
  output logic [`EX_XLEN-1:0]   wb_result_o,
  output logic [`EX_REG_AW-1:0] wb_rd_o
);
  import ex_ctrl_pkg::*;

  logic   can_load;
  logic   in_valid;
  ex_wb_t in_data;
  logic   wb_valid_q;
  ex_wb_t wb_q;

  ////////////////////////////////////////////////////////////////////////////
  // Ready towards the units and the issue port
  ////////////////////////////////////////////////////////////////////////////

  // Register is empty or its content leaves this cycle
  assign can_load = !wb_valid_q || wb_ready_i;

  assign alu_res.ready = can_load;
  assign md_res.ready  = can_load;

  // No new issue while a multiply or divide is in flight
  assign issue_ready_o = can_load && !md_busy_i;

  // Pick the unit that has something
  assign in_valid = alu_res.valid || md_res.valid;
  assign in_data  = alu_res.valid ? alu_res.payload : md_res.payload;

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
    end else if (can_load) begin
      // Load a new result, or drop to empty on a plain drain
      wb_valid_q <= in_valid;
    end
  end

  // Payload only moves on a load, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (can_load && in_valid) begin
      wb_q <= in_data;
    end
  end

  assign wb_valid_o  = wb_valid_q;
  assign wb_result_o = wb_q.result;
  assign wb_rd_o     = wb_q.rd;

endmodule

// File: verilog/ex_stage.sv
/*
  Integer execute stage: ALU and multiply/divide side by side,
  merged into one EX/WB register. One operation is issued at a time.
  branch_taken_o is combinational from the issue inputs.
*/

`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue_valid_i,
  input  ex_op_pkg::ex_op_e     issue_op_i,
  input  logic [`EX_XLEN-1:0]   op_a_i,
  input  logic [`EX_XLEN-1:0]   op_b_i,
  input  logic [`EX_REG_AW-1:0] rd_i,
  input  logic                  wb_ready_i,
  output logic                  issue_ready_o,
  output logic                  branch_taken_o,
  output logic                  wb_valid_o,
  output logic [`EX_XLEN-1:0]   wb_result_o,
  output logic [`EX_REG_AW-1:0] wb_rd_o
);

  // Multiply/divide unit is working
  logic md_busy;

  // One result channel per unit
  ex_result_if alu_res ();
  ex_result_if md_res ();

  ////////////////////////////////////////////////////////////////////////////
  // Execute units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .issue_valid_i  (issue_valid_i),
    .issue_ready_i  (issue_ready_o),
    .issue_op_i     (issue_op_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .rd_i           (rd_i),
    .branch_taken_o (branch_taken_o),
    .res            (alu_res.unit)
  );

  ex_muldiv u_muldiv (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid_i),
    .issue_ready_i (issue_ready_o),
    .issue_op_i    (issue_op_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .rd_i          (rd_i),
    .busy_o        (md_busy),
    .res           (md_res.unit)
  );

  // EX/WB register and issue flow control
  ex_wb_reg u_wb_reg (
    .clk           (clk),
    .rst_n         (rst_n),
    .alu_res       (alu_res.wb),
    .md_res        (md_res.wb),
    .md_busy_i     (md_busy),
    .wb_ready_i    (wb_ready_i),
    .issue_ready_o (issue_ready_o),
    .wb_valid_o    (wb_valid_o),
    .wb_result_o   (wb_result_o),
    .wb_rd_o       (wb_rd_o)
  );

endmodule

// File: bench/ex_stage_tb.sv
/*
  Testbench for the integer execute stage, driven on the falling edge.
  Expected values come from a model of the ALU, branch and unsigned
  multiply/divide rules and are checked in issue order.
  Back-pressure on wb_ready_i is random only in the last test.
*/

`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_stage_tb;
  import ex_op_pkg::*;
  import ex_ctrl_pkg::*;

  // Upper bound on issued operations, sizes the watchdog
  localparam int NUM_OPS = 130;

  logic                  clk;
  logic                  rst_n;
  logic                  issue_valid_i;
  ex_op_e                issue_op_i;
  logic [`EX_XLEN-1:0]   op_a_i;
  logic [`EX_XLEN-1:0]   op_b_i;
  logic [`EX_REG_AW-1:0] rd_i;
  logic                  wb_ready_i;
  logic                  issue_ready_o;
  logic                  branch_taken_o;
  logic                  wb_valid_o;
  logic [`EX_XLEN-1:0]   wb_result_o;
  logic [`EX_REG_AW-1:0] wb_rd_o;

  // Separate streams so operands and back-pressure never share a draw
  integer      seed;
  integer      bp_seed;
  logic [31:0] bp_rnd;
  logic        bp_en;
  // Expected results in issue order
  ex_wb_t      exp_q[$];
  ex_wb_t      exp_w;
  // Content seen under back-pressure on the previous edge
  logic        held;
  ex_wb_t      held_w;
  // Multiply or divide accepted, result not yet in the EX/WB register
  logic        md_wait;
  int          errors;
  int          tests_run;
  int          tests_failed;

  ex_stage uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue_valid_i  (issue_valid_i),
    .issue_op_i     (issue_op_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .rd_i           (rd_i),
    .wb_ready_i     (wb_ready_i),
    .issue_ready_o  (issue_ready_o),
    .branch_taken_o (branch_taken_o),
    .wb_valid_o     (wb_valid_o),
    .wb_result_o    (wb_result_o),
    .wb_rd_o        (wb_rd_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] expected_result(input ex_op_e op, input logic [31:0] a,
                                                  input logic [31:0] b);
    logic [63:0] prod;
    prod = {32'h0, a} * {32'h0, b};
    case (op)
      ADD:   return a + b;
      SUB:   return a - b;
      AND:   return a & b;
      OR:    return a | b;
      XOR:   return a ^ b;
      SLL:   return a << b[4:0];
      SRL:   return a >> b[4:0];
      SRA:   return $signed(a) >>> b[4:0];
      SLT:   return {31'h0, $signed(a) < $signed(b)};
      SLTU:  return {31'h0, a < b};
      MUL:   return prod[31:0];
      MULHU: return prod[63:32];
      // Zero divisor: all ones, remainder keeps the dividend
      DIVU:  return (b == 32'h0) ? 32'hffff_ffff : a / b;
      REMU:  return (b == 32'h0) ? a : a % b;
      // Branches write zero
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic branch_decision(input ex_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
    case (op)
      BEQ:  return a == b;
      BNE:  return a != b;
      BLT:  return $signed(a) < $signed(b);
      BGE:  return $signed(a) >= $signed(b);
      BLTU: return a < b;
      BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic report_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
    $display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp, got);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor and assertions
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      // Held content must not move
      if (held) begin
        assert (wb_result_o == held_w.result)
          else report_value("wb_result_o", held_w.result, wb_result_o);
        assert (wb_rd_o == held_w.rd)
          else report_value("wb_rd_o", 32'(held_w.rd), 32'(wb_rd_o));
      end
      if (wb_valid_o && wb_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Result transferred at %0d ns with nothing expected", $time);
          errors++;
        end else begin
          exp_w = exp_q.pop_front();
          assert (wb_result_o == exp_w.result)
            else report_value("wb_result_o", exp_w.result, wb_result_o);
          assert (wb_rd_o == exp_w.rd)
            else report_value("wb_rd_o", 32'(exp_w.rd), 32'(wb_rd_o));
        end
      end
      held          = wb_valid_o && !wb_ready_i;
      held_w.result = wb_result_o;
      held_w.rd     = wb_rd_o;
      // Track a multiply/divide from accept to its write
      if (md_wait && wb_valid_o) begin
        md_wait <= 1'b0;
      end
      if (issue_valid_i && issue_ready_o && (issue_op_i inside {MUL, MULHU, DIVU, REMU})) begin
        md_wait <= 1'b1;
      end
    end else begin
      md_wait <= 1'b0;
    end
  end

  // Issue stays stalled while a multiply/divide is in flight
  md_stall_chk: assert property (@(posedge clk) disable iff (!rst_n)
                                 (md_wait && !wb_valid_o) |-> !issue_ready_o)
    else begin
      $display("Issue ready went high at %0d ns during a multiply/divide", $time);
      errors++;
    end

  // A stalled result stays valid
  hold_valid_chk: assert property (@(posedge clk) disable iff (!rst_n)
                                   (wb_valid_o && !wb_ready_i) |=> wb_valid_o)
    else begin
      $display("wb_valid_o dropped at %0d ns before its transfer", $time);
      errors++;
    end

  // Random back-pressure, about three ready cycles in four
  always @(negedge clk) begin
    if (bp_en) begin
      bp_rnd     = $random(bp_seed);
      wb_ready_i = bp_rnd[0] | bp_rnd[1];
    end else begin
      wb_ready_i = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue_op(input ex_op_e op, input logic [31:0] a, input logic [31:0] b,
                          input logic [`EX_REG_AW-1:0] rd);
    logic accepted;
    @(negedge clk);
    issue_valid_i = 1'b1;
    issue_op_i    = op;
    op_a_i        = a;
    op_b_i        = b;
    rd_i          = rd;
    accepted      = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = issue_ready_o;
    end
    // Branch decision is combinational in the accept cycle
    assert (branch_taken_o == branch_decision(op, a, b))
      else report_value("branch_taken_o", 32'(branch_decision(op, a, b)), 32'(branch_taken_o));
    exp_w.result = expected_result(op, a, b);
    exp_w.rd     = rd;
    exp_q.push_back(exp_w);
  endtask

  task automatic finish_test(input string name, input int start);
    @(negedge clk);
    issue_valid_i = 1'b0;
    while (exp_q.size() != 0 || md_wait) begin
      @(posedge clk);
    end
    bp_en = 1'b0;
    tests_run++;
    if (errors != start) begin
      tests_failed++;
    end
    $display("Test %-10s %s, %0d errors", name, (errors == start) ? "ok" : "FAILED",
             errors - start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    ex_op_e      op;
    int          start;
    seed          = 32'hcd1a;
    bp_seed       = seed;
    bp_en         = 1'b0;
    held          = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    rst_n         = 1'b0;
    issue_valid_i = 1'b0;
    issue_op_i    = ADD;
    op_a_i        = '0;
    op_b_i        = '0;
    rd_i          = '0;
    wb_ready_i    = 1'b1;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Idle state out of reset
    start = errors;
    @(posedge clk);
    assert (!wb_valid_o) else report_value("wb_valid_o", 32'h0, 32'(wb_valid_o));
    assert (issue_ready_o) else report_value("issue_ready_o", 32'h1, 32'(issue_ready_o));
    finish_test("reset", start);

    start = errors;
    for (int i = int'(ADD); i <= int'(SLTU); i++) begin
      repeat (4) begin
        a = $random(seed);
        b = $random(seed);
        issue_op(ex_op_e'(i), a, b, 5'($random(seed)));
      end
    end
    finish_test("alu_ops", start);

    // Boundary pairs catch signed and unsigned mix-ups
    start = errors;
    for (int i = int'(BEQ); i <= int'(BGEU); i++) begin
      issue_op(ex_op_e'(i), 32'h0, 32'h0, 5'd0);
      issue_op(ex_op_e'(i), 32'h8000_0000, 32'h7fff_ffff, 5'd0);
      issue_op(ex_op_e'(i), 32'h7fff_ffff, 32'h8000_0000, 5'd0);
      issue_op(ex_op_e'(i), 32'hffff_ffff, 32'h0000_0001, 5'd0);
      a = $random(seed);
      issue_op(ex_op_e'(i), a, a, 5'd0);
      issue_op(ex_op_e'(i), a, $random(seed), 5'd0);
    end
    finish_test("branches", start);

    start = errors;
    for (int i = int'(MUL); i <= int'(REMU); i++) begin
      for (int k = 0; k < 4; k++) begin
        a = $random(seed);
        b = $random(seed);
        // Short divisors give non-trivial quotients
        if (k[0]) begin
          b = b >> 20;
        end
        issue_op(ex_op_e'(i), a, b, 5'($random(seed)));
      end
      issue_op(ex_op_e'(i), $random(seed), 32'h0, 5'($random(seed)));
    end
    finish_test("muldiv", start);

    // Mixed traffic with a stalling consumer
    start = errors;
    bp_en = 1'b1;
    repeat (24) begin
      r  = $random(seed);
      op = ex_op_e'(5'(r % 32'd20));
      a  = $random(seed);
      b  = $random(seed);
      if (op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU}) begin
        issue_op(op, a, b, 5'd0);
      end else begin
        issue_op(op, a, b, 5'($random(seed)));
      end
    end
    finish_test("backpress", start);

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog, 40 cycles per operation
  initial begin
    #(NUM_OPS * 40 * 40);
    $display("Watchdog expired at %0d ns, the run did not finish", $time);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+verilog
verilog/ex_op_pkg.sv
verilog/ex_ctrl_pkg.sv
verilog/ex_result_if.sv
verilog/ex_alu.sv
verilog/ex_muldiv.sv
verilog/ex_wb_reg.sv
verilog/ex_stage.sv
bench/ex_stage_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = ex_stage_tb
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, pass or fail from $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
